// ==== hdl/mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// data RAM size in 32-bit words, must be a power of two.
`define MEM_WORDS 2048

// transmit ring, 256 byte addresses starting here.
`define MMIO_TX_BUF_BASE 32'hff000000

// tail index, written by the master to queue bytes.
`define MMIO_TX_TAIL_ADDR 32'hff000100

// head index, owned by the transmitter, read only on the bus.
`define MMIO_TX_HEAD_ADDR 32'hff000101

// serial bit time in clock cycles.
`define UART_CLKS_PER_BIT 8

`endif

// ==== hdl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // one access, qualified by the req_valid strobe.
    typedef struct packed {
        logic        write;  // 1 for a write, 0 for a read.
        logic [31:0] addr;   // byte address.
        logic [31:0] wdata;  // ignored on reads.
    } bus_req_t;

    // read response, one cycle after the read strobe.
    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } bus_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    // index into the 256 byte transmit ring.
    typedef logic [7:0] tx_idx_t;

    // serializer phases of one 8N1 frame.
    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } tx_state_e;

endpackage

`default_nettype wire

// ==== hdl/data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module data_memory
    import bus_pkg::*;
    import uart_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              req_valid,
    input  wire bus_req_t    req,
    output bus_rsp_t         rsp,
    output tx_idx_t          tx_tail,
    input  wire tx_idx_t     tx_head,
    input  wire tx_idx_t     tx_rd_idx,
    output logic [7:0]       tx_rd_byte
);

    localparam int word_bits = $clog2(`MEM_WORDS);

    localparam logic [31:0] buf_base  = `MMIO_TX_BUF_BASE;
    localparam logic [31:0] tail_addr = `MMIO_TX_TAIL_ADDR;
    localparam logic [31:0] head_addr = `MMIO_TX_HEAD_ADDR;

    logic [31:0] ram [`MEM_WORDS];
    logic [7:0]  ring [256];

    logic                 is_ring;
    logic                 is_tail;
    logic                 is_head;
    logic                 is_ram;
    logic                 rd_strobe;
    logic                 wr_strobe;
    logic [word_bits-1:0] word_idx;
    tx_idx_t              ring_idx;
    tx_idx_t              tail_q;

    logic                 rsp_valid_q;
    logic                 sel_ram_q;    // response comes from the RAM word.
    logic [31:0]          ram_word_q;
    logic [7:0]           mmio_byte_q;
    logic [7:0]           mmio_byte;

    // stored words keep their bytes in reverse order.
    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign rd_strobe = req_valid && !req.write;
    assign wr_strobe = req_valid && req.write;

    // region decode.
    assign is_ring  = (req.addr[31:8] == buf_base[31:8]);
    assign is_tail  = (req.addr == tail_addr);
    assign is_head  = (req.addr == head_addr);
    assign is_ram   = !(is_ring || is_tail || is_head);

    assign ring_idx = req.addr[7:0] - buf_base[7:0];
    assign word_idx = req.addr[word_bits+1:2];  // wraps modulo the RAM depth.

    // RAM and ring storage.
    always_ff @(posedge clk) begin
        if (wr_strobe) begin
            if (is_ring) begin
                ring[ring_idx] <= req.wdata[7:0];
            end else if (is_ram) begin
                ram[word_idx] <= swap_bytes(req.wdata);
            end
        end
    end

    // writes to the head address fall through here and are dropped.
    always_ff @(posedge clk) begin
        if (rst) begin
            tail_q <= '0;
        end else if (wr_strobe && is_tail) begin
            tail_q <= req.wdata[7:0];
        end
    end

    always_comb begin
        if (is_ring) begin
            mmio_byte = ring[ring_idx];
        end else if (is_tail) begin
            mmio_byte = tail_q;
        end else begin
            mmio_byte = tx_head;  // only meaningful when is_head.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= rd_strobe;
        end
    end

    // read payload captured on each read strobe.
    always_ff @(posedge clk) begin
        if (rd_strobe) begin
            sel_ram_q   <= is_ram;
            ram_word_q  <= ram[word_idx];
            mmio_byte_q <= mmio_byte;
        end
    end

    assign rsp.valid = rsp_valid_q;
    assign rsp.rdata = sel_ram_q ? swap_bytes(ram_word_q) : {24'b0, mmio_byte_q};

    // transmitter side of the ring.
    assign tx_tail    = tail_q;
    assign tx_rd_byte = ring[tx_rd_idx];

    // a RAM read right after a write to the same word returns the written word.
    a_ram_round_trip: assert property (
        @(posedge clk) disable iff (rst)
        rd_strobe && is_ram && $past(wr_strobe && is_ram)
            && (word_idx == $past(word_idx))
            |=> (rsp.rdata == $past(req.wdata, 2))
    );

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module uart_tx
    import uart_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire tx_idx_t     tail,
    output tx_idx_t          rd_idx,
    input  wire [7:0]        rd_byte,
    output tx_idx_t          head,
    output logic             tx
);

    localparam int cnt_bits = $clog2(`UART_CLKS_PER_BIT + 1);
    localparam logic [cnt_bits-1:0] cnt_last = cnt_bits'(`UART_CLKS_PER_BIT - 1);

    tx_state_e           state;
    tx_idx_t             head_q;
    logic [cnt_bits-1:0] baud_cnt;
    logic [2:0]          bit_cnt;
    logic [7:0]          shreg;
    logic                tx_q;
    logic                bit_done;
    logic                launch;

    assign bit_done = (baud_cnt == cnt_last);
    assign launch   = (state == st_idle) && (head_q != tail);  // queue not empty.

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            head_q   <= '0;
            tx_q     <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    baud_cnt <= '0;
                    if (launch) begin
                        state <= st_start;
                        tx_q  <= 1'b0;  // start bit.
                    end
                end
                st_start: begin
                    baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
                    if (bit_done) begin
                        state   <= st_data;
                        tx_q    <= shreg[0];
                        bit_cnt <= '0;
                    end
                end
                st_data: begin
                    baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
                    if (bit_done) begin
                        if (bit_cnt == 3'd7) begin
                            state <= st_stop;
                            tx_q  <= 1'b1;  // stop bit.
                        end else begin
                            tx_q    <= shreg[1];  // next bit after the shift below.
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end
                end
                st_stop: begin
                    baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
                    if (bit_done) begin
                        state  <= st_idle;
                        head_q <= head_q + 8'd1;  // byte fully sent.
                    end
                end
                default: begin
                    state <= st_idle;
                    tx_q  <= 1'b1;
                end
            endcase
        end
    end

    // frame payload, LSB leaves first.
    always_ff @(posedge clk) begin
        if (launch) begin
            shreg <= rd_byte;
        end else if (state == st_data && bit_done) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

    assign rd_idx = head_q;
    assign head   = head_q;
    assign tx     = tx_q;

    a_idle_line_high: assert property (
        @(posedge clk) disable iff (rst)
        state == st_idle |-> tx
    );

    // head only steps forward by one, and only over queued bytes.
    a_head_step: assert property (
        @(posedge clk) disable iff (rst)
        $changed(head_q) |-> (head_q == tx_idx_t'($past(head_q) + 8'd1))
                             && $past(head_q != tail)
    );

endmodule

`default_nettype wire

// ==== hdl/mem_uart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_uart_top
    import bus_pkg::*;
    import uart_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              req_valid,
    input  wire bus_req_t    req,
    output bus_rsp_t         rsp,
    output logic             tx
);

    tx_idx_t    tail_idx;
    tx_idx_t    head_idx;
    tx_idx_t    ring_rd_idx;
    logic [7:0] ring_rd_byte;

    data_memory u_mem (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .rsp        (rsp),
        .tx_tail    (tail_idx),
        .tx_head    (head_idx),
        .tx_rd_idx  (ring_rd_idx),
        .tx_rd_byte (ring_rd_byte)
    );

    // drains the ring from head up to tail.
    uart_tx u_tx (
        .clk     (clk),
        .rst     (rst),
        .tail    (tail_idx),
        .rd_idx  (ring_rd_idx),
        .rd_byte (ring_rd_byte),
        .head    (head_idx),
        .tx      (tx)
    );

endmodule

`default_nettype wire

// ==== test/tb_mem_uart.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module tb_mem_uart
    import bus_pkg::*;
();

    localparam int clk_ns       = 10;
    localparam int bit_ns       = `UART_CLKS_PER_BIT * clk_ns;
    localparam int golden_words = 256;
    localparam int reset_cyc    = 4;
    localparam int margin_cyc   = 200;

    localparam logic [31:0] op_wait  = 32'h0;
    localparam logic [31:0] op_write = 32'h1;
    localparam logic [31:0] op_read  = 32'h2;

    logic     clk;
    logic     rst;
    logic     req_valid;
    bus_req_t req;
    bus_rsp_t rsp;
    logic     tx;

    logic [31:0] golden [golden_words];  // header, vectors, then expected characters.
    logic [31:0] exp_q [$];              // expected read data, oldest first.

    int n_vec;
    int n_chr;
    int chr_base;
    int chars_seen;
    int read_errors;
    int char_errors;
    int timeouts;
    bit loaded;

    mem_uart_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .rsp       (rsp),
        .tx        (tx)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_ns / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, output bit ok);
        ok = (actual === expected);
        if (!ok) begin
            $display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic finish_run();
        $display("read errors %0d, character errors %0d, timeouts %0d",
                 read_errors, char_errors, timeouts);
        if (read_errors == 0 && char_errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    // bus driver, one vector per cycle.
    initial begin : driver
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_val;
        int          base;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        $readmemh("test/mem_uart_golden.hex", golden);
        if ($isunknown(golden[0]) || $isunknown(golden[1]) || golden[0] == 0) begin
            $display("golden file is missing or has no vectors");
            read_errors++;
            finish_run();
        end else begin
            n_vec    = golden[0];
            n_chr    = golden[1];
            chr_base = 2 + 4 * n_vec;
            loaded   = 1'b1;
            repeat (reset_cyc) @(posedge clk);
            #1;
            rst = 1'b0;
            for (int i = 0; i < n_vec; i++) begin
                base    = 2 + 4 * i;
                op      = golden[base];
                addr    = golden[base + 1];
                wdata   = golden[base + 2];
                exp_val = golden[base + 3];
                if (op == op_wait) begin
                    req_valid = 1'b0;
                    repeat (wdata) @(posedge clk);  // idle cycles.
                end else if (op == op_write || op == op_read) begin
                    req_valid = 1'b1;
                    req.write = (op == op_write);
                    req.addr  = addr;
                    req.wdata = wdata;
                    if (op == op_read) begin
                        exp_q.push_back(exp_val);
                    end
                    @(posedge clk);
                end else begin
                    $display("vector %0d has an unknown operation code %h", i, op);
                    read_errors++;
                    req_valid = 1'b0;
                    @(posedge clk);
                end
                #1;
            end
            req_valid = 1'b0;
            wait (chars_seen >= n_chr);
            repeat (2) @(posedge clk);
            if (exp_q.size() != 0) begin
                $display("%0d read responses never arrived", exp_q.size());
                read_errors += exp_q.size();
            end
            finish_run();
        end
    end

    // read responses, sampled away from the active edge.
    initial begin : rsp_monitor
        logic [31:0] expected;
        bit          ok;
        forever begin
            @(negedge clk);
            if (!rst && rsp.valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("response seen with no read outstanding at %0t", $time);
                    read_errors++;
                end else begin
                    expected = exp_q.pop_front();
                    check_value("rsp.rdata", expected, rsp.rdata, ok);
                    if (!ok) begin
                        read_errors++;
                    end
                end
            end
        end
    end

    // serial line monitor, samples mid bit.
    initial begin : line_monitor
        logic [7:0] data;
        bit         ok;
        wait (loaded && !rst);
        forever begin
            @(negedge tx);
            #(bit_ns / 2);
            if (tx !== 1'b0) begin
                $display("start bit on tx ended early at %0t", $time);
                char_errors++;
            end else begin
                for (int i = 0; i < 8; i++) begin
                    #(bit_ns);
                    data[i] = tx;  // lsb first.
                end
                #(bit_ns);
                if (tx !== 1'b1) begin
                    $display("missing stop bit after character %0d at %0t", chars_seen, $time);
                    char_errors++;
                end
                if (chars_seen >= n_chr) begin
                    $display("unexpected extra character %h on tx at %0t", data, $time);
                    char_errors++;
                end else begin
                    check_value("tx", golden[chr_base + chars_seen], {24'b0, data}, ok);
                    if (!ok) begin
                        char_errors++;
                    end
                end
                chars_seen++;
            end
        end
    end

    // bounds the run by the vector count and the frame time of all characters.
    initial begin : watchdog
        int limit_cyc;
        wait (loaded);
        limit_cyc = reset_cyc + n_vec + n_chr * 10 * `UART_CLKS_PER_BIT + margin_cyc;
        #(limit_cyc * clk_ns);
        $display("timeout after %0d cycles, the run did not finish", limit_cyc);
        timeouts++;
        finish_run();
    end

endmodule

`default_nettype wire

// ==== test/mem_uart_golden.hex ====
// header: vector count, expected character count.
// vector: op (0 wait, 1 write, 2 read), address, write data or wait cycles, expected read data.
1b 5
// head reads zero after reset.
2 ff000101 00000000 00000000
// ram round trip through the swapped storage.
1 00000010 12345678 00000000
2 00000010 00000000 12345678
// low address bits ignored.
1 00000020 deadbeef 00000000
2 00000023 00000000 deadbeef
// aliasing beyond the ram depth.
1 00000040 cafef00d 00000000
2 00002040 00000000 cafef00d
1 00004086 a5a55a5a 00000000
2 00000084 00000000 a5a55a5a
// ring bytes keep only the low data byte.
1 ff000080 aabbccdd 00000000
2 ff000080 00000000 000000dd
1 ff0000ff 000001ee 00000000
2 ff0000ff 00000000 000000ee
// queue five characters.
1 ff000000 00000048 00000000
1 ff000001 00000065 00000000
1 ff000002 abcd0079 00000000
1 ff000003 000000ff 00000000
1 ff000004 00000000 00000000
2 ff000002 00000000 00000079
// advance tail, then try to write head.
1 ff000100 00000005 00000000
2 ff000100 00000000 00000005
1 ff000101 00000003 00000000
2 ff000101 00000000 00000000
2 00000010 00000000 12345678
// let the transmitter drain the ring.
0 00000000 000001c2 00000000
2 ff000101 00000000 00000005
2 ff000100 00000000 00000005
// expected characters on tx, in ring order.
48
65
79
ff
00

// ==== vlog.f ====
+incdir+hdl
hdl/bus_pkg.sv
hdl/uart_pkg.sv
hdl/data_memory.sv
hdl/uart_tx.sv
hdl/mem_uart_top.sv
test/tb_mem_uart.sv

// ==== Bender.yml ====
package:
  name: mem_uart

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/bus_pkg.sv
      - hdl/uart_pkg.sv
      - hdl/data_memory.sv
      - hdl/uart_tx.sv
      - hdl/mem_uart_top.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_mem_uart.sv
